/* common/palette_params.svh */
`ifndef PALETTE_PARAMS_SVH
`define PALETTE_PARAMS_SVH

// number of colors in the palette
`define PAL_ENTRIES 256

// source bytes, three per color in R, G, B order
`define PAL_BYTES 768

// byte address width of the memory read port
`define MEM_ADDR_W 32

`endif

/* common/palette_pkg.sv */
// types shared by the palette loader, store and lookup
package palette_pkg;

  // channel order inside one color, same as the byte order in memory
  typedef enum logic [1:0] {
    CH_R = 2'd0,  // first byte of a color
    CH_G = 2'd1,  // second byte
    CH_B = 2'd2   // third byte, 2'd3 is never used
  } channel_t;

  // display format, red in the top bits
  typedef struct packed {
    logic [4:0] r;  // top 5 bits of the red byte
    logic [5:0] g;  // top 6 bits of the green byte
    logic [4:0] b;  // top 5 bits of the blue byte
  } rgb565_t;

  // one palette entry
  // the store fills it one field at a time,
  // the lookup sends it out as a plain 16-bit word
  typedef union packed {
    logic [15:0] raw;  // word as seen on the video side
    rgb565_t     rgb;  // field view for channel writes
  } palette_word_u;

endpackage

/* common/palette_wr_if.sv */
`timescale 1ns/1ns

// one channel write per fetched byte, loader to store
interface palette_wr_if;

  logic                  wr_en;       // single cycle strobe
  logic [7:0]            wr_index;    // color being updated
  palette_pkg::channel_t wr_channel;  // which field of the color
  logic [7:0]            wr_data;     // raw byte, store does the reduction

  // loader side
  modport src (
    output wr_en,
    output wr_index,
    output wr_channel,
    output wr_data
  );

  // store side, no back-pressure
  modport dst (
    input wr_en,
    input wr_index,
    input wr_channel,
    input wr_data
  );

endinterface

/* loader/palette_loader.sv */
`timescale 1ns/1ns
`include "palette_params.svh"

module palette_loader (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,            // load request ignored while busy
  input  logic [`MEM_ADDR_W-1:0] base_addr,        // address of the first red byte
  output logic                   busy,             // high from the edge after start up to done
  output logic                   done,             // one cycle after the last write
  output logic [`MEM_ADDR_W-1:0] mem_address,      // base plus offset
  output logic                   mem_read,         // held through wait states
  input  logic                   mem_waitrequest,
  input  logic [7:0]             mem_readdata,     // valid when the read completes
  palette_wr_if.src              wr
);

  localparam int OFF_W = $clog2(`PAL_BYTES);    // 10 bits for 768 bytes
  localparam int IDX_W = $clog2(`PAL_ENTRIES);  // 8 bits for 256 colors

  typedef enum logic [1:0] {
    ST_IDLE,    // waiting for start
    ST_REQ,     // mem_read high until waitrequest drops
    ST_WRITE,   // wr_en pulse for the captured byte
    ST_FINISH   // done pulse
  } state_t;

  state_t                  state;      // seq
  logic [`MEM_ADDR_W-1:0]  base_q;     // latched at start
  logic [OFF_W-1:0]        offset;     // byte offset from base
  logic [IDX_W-1:0]        color_idx;  // seq
  palette_pkg::channel_t   chan;       // steps R G B
  palette_pkg::channel_t   chan_next;  // comb
  logic [7:0]              data_q;     // byte from the completed read

  // mod-3 step of the channel counter
  always_comb begin
    case (chan)
      palette_pkg::CH_R: chan_next = palette_pkg::CH_G;
      palette_pkg::CH_G: chan_next = palette_pkg::CH_B;
      default:           chan_next = palette_pkg::CH_R;  // blue wraps to next color
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      offset    <= '0;
      color_idx <= '0;
      chan      <= palette_pkg::CH_R;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state     <= ST_REQ;
            base_q    <= base_addr;  // later changes on base_addr have no effect
            offset    <= '0;
            color_idx <= '0;
            chan      <= palette_pkg::CH_R;
          end
        end
        ST_REQ: begin
          if (!mem_waitrequest) begin  // read completes this cycle
            data_q <= mem_readdata;
            state  <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (offset == OFF_W'(`PAL_BYTES - 1)) begin
            state <= ST_FINISH;  // last blue byte written
          end else begin
            offset <= offset + 1'b1;
            chan   <= chan_next;
            if (chan == palette_pkg::CH_B) color_idx <= color_idx + 1'b1;
            state  <= ST_REQ;  // next request one cycle after the write
          end
        end
        default: begin
          state <= ST_IDLE;  // finish lasts one cycle
        end
      endcase
    end
  end

  assign busy        = (state != ST_IDLE);  // falls with done
  assign done        = (state == ST_FINISH);
  assign mem_read    = (state == ST_REQ);
  assign mem_address = base_q + `MEM_ADDR_W'(offset);

  // counters only move after the write, so index and channel match the byte
  assign wr.wr_en      = (state == ST_WRITE);
  assign wr.wr_index   = color_idx;
  assign wr.wr_channel = chan;
  assign wr.wr_data    = data_q;

  // address must not move while the memory stalls the read
  a_addr_stable : assert property (@(posedge clk) disable iff (reset)
    (mem_read && mem_waitrequest) |=> (mem_read && $stable(mem_address)));

  // color index and channel of a write always point at the byte offset
  a_wr_position : assert property (@(posedge clk) disable iff (reset)
    wr.wr_en |-> (int'(offset) == int'(color_idx) * 3 + int'(chan)));

endmodule

/* verilog/palette_store.sv */
`timescale 1ns/1ns
`include "palette_params.svh"

module palette_store (
  input  logic                       clk,
  input  logic                       reset,
  palette_wr_if.dst                  wr,
  input  logic [7:0]                 rd_index,  // sampled every edge
  output palette_pkg::palette_word_u rd_data    // entry for the index of the last edge
);

  palette_pkg::palette_word_u mem [`PAL_ENTRIES];  // seq, one RGB565 word per color
  logic [7:0]                 rd_idx_q;            // seq, registered read address

  // channel writes with the depth reduction
  // only the addressed field changes, the other two keep their value
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `PAL_ENTRIES; i++) begin
        mem[i] <= '0;  // palette starts black
      end
    end else if (wr.wr_en) begin
      case (wr.wr_channel)
        palette_pkg::CH_R: mem[wr.wr_index].rgb.r <= wr.wr_data[7:3];  // >> 3
        palette_pkg::CH_G: mem[wr.wr_index].rgb.g <= wr.wr_data[7:2];  // >> 2
        palette_pkg::CH_B: mem[wr.wr_index].rgb.b <= wr.wr_data[7:3];  // >> 3
        default: ;  // unused code, flagged below
      endcase
    end
  end

  // read port, one edge of latency
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_idx_q <= '0;
    end else begin
      rd_idx_q <= rd_index;
    end
  end

  assign rd_data = mem[rd_idx_q];  // comb from the registered index

  // the loader channel counter only ever produces R, G and B
  a_valid_channel : assert property (@(posedge clk) disable iff (reset)
    wr.wr_en |-> (wr.wr_channel inside {palette_pkg::CH_R,
                                        palette_pkg::CH_G,
                                        palette_pkg::CH_B}));

endmodule

/* verilog/pixel_lookup.sv */
`timescale 1ns/1ns

module pixel_lookup (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       pix_valid,  // one pixel per cycle at most
  input  logic [7:0]                 pix_index,  // palette index of the pixel
  output logic [7:0]                 rd_index,   // to the store read port
  input  palette_pkg::palette_word_u rd_data,    // one edge after rd_index
  output logic                       rgb_valid,  // pix_valid two cycles later
  output logic [15:0]                rgb         // zero while not valid
);

  logic        valid_s1;  // seq, pixel waiting on the store read
  logic        valid_s2;  // seq, output stage
  logic [15:0] rgb_q;     // seq, output word

  // stage 1 is the store's registered read
  assign rd_index = pix_index;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
      rgb_q    <= '0;
    end else begin
      valid_s1 <= pix_valid;
      valid_s2 <= valid_s1;
      // stage 2 takes the word out raw
      rgb_q    <= valid_s1 ? rd_data.raw : 16'h0000;
    end
  end

  assign rgb_valid = valid_s2;
  assign rgb       = rgb_q;

  // fixed latency through this module and the store read port
  a_two_cycle : assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> ##2 rgb_valid);

  a_no_extra : assert property (@(posedge clk) disable iff (reset)
    !pix_valid |-> ##2 !rgb_valid);

endmodule

/* verilog/palette_top.sv */
`timescale 1ns/1ns
`include "palette_params.svh"

module palette_top (
  input  logic                   clk,
  input  logic                   reset,
  // load control
  input  logic                   start,
  input  logic [`MEM_ADDR_W-1:0] base_addr,
  output logic                   busy,
  output logic                   done,
  // byte memory read port
  output logic [`MEM_ADDR_W-1:0] mem_address,
  output logic                   mem_read,
  input  logic                   mem_waitrequest,
  input  logic [7:0]             mem_readdata,
  // pixel stream
  input  logic                   pix_valid,
  input  logic [7:0]             pix_index,
  output logic                   rgb_valid,
  output logic [15:0]            rgb
);

  palette_wr_if               wr_bus ();  // loader to store channel writes
  logic [7:0]                 rd_index;   // lookup to store
  palette_pkg::palette_word_u rd_data;    // store to lookup

  palette_loader u_loader (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .base_addr       (base_addr),
    .busy            (busy),
    .done            (done),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_readdata    (mem_readdata),
    .wr              (wr_bus.src)
  );

  palette_store u_store (
    .clk      (clk),
    .reset    (reset),
    .wr       (wr_bus.dst),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  pixel_lookup u_lookup (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .pix_index (pix_index),
    .rd_index  (rd_index),
    .rd_data   (rd_data),
    .rgb_valid (rgb_valid),
    .rgb       (rgb)
  );

endmodule

/* verif/palette_tb.sv */
`timescale 1ns/1ns
`include "palette_params.svh"

module palette_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int MEM_SIZE        = 2048;                     // bytes in the memory model
  localparam int LOAD_LIMIT      = `PAL_BYTES * 6;           // worst case is 5 cycles per byte
  localparam int WATCHDOG_CYCLES = 4 * `PAL_BYTES * 6 + 2000;

  logic                   clk;
  logic                   reset;
  logic                   start;
  logic [`MEM_ADDR_W-1:0] base_addr;
  logic                   busy;
  logic                   done;
  logic [`MEM_ADDR_W-1:0] mem_address;
  logic                   mem_read;
  logic                   mem_waitrequest = 1'b0;  // owned by the memory model
  logic [7:0]             mem_readdata;
  logic                   pix_valid;
  logic [7:0]             pix_index;
  logic                   rgb_valid;
  logic [15:0]            rgb;

  logic [7:0]  mem_bytes [MEM_SIZE];  // memory contents, random fill
  int          wait_left;             // stall cycles left for the open request
  logic [31:0] reads [$];             // addresses of completed reads, current load
  int          done_count;            // done pulses seen, current load
  int          error_count;
  int          check_count;

  palette_top u_palette_top (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .base_addr       (base_addr),
    .busy            (busy),
    .done            (done),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_readdata    (mem_readdata),
    .pix_valid       (pix_valid),
    .pix_index       (pix_index),
    .rgb_valid       (rgb_valid),
    .rgb             (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory model, stall length picked before each request starts
  always @(posedge clk) begin
    if (reset) begin
      wait_left = 0;
      mem_waitrequest <= 1'b0;
    end else if (mem_read && mem_waitrequest) begin  // request still stalled
      wait_left = wait_left - 1;
      mem_waitrequest <= (wait_left > 0);
    end else begin  // idle or completing, pick 0 to 3 waits for the next one
      wait_left = int'($urandom_range(3, 0));
      mem_waitrequest <= (wait_left > 0);
    end
  end

  assign mem_readdata = mem_bytes[mem_address[10:0]];  // follows the address

  // read and done monitor, mid cycle where everything is settled
  always @(negedge clk) begin
    if (!reset && mem_read && !mem_waitrequest) reads.push_back(mem_address);
    if (!reset && done) done_count++;
  end

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    $display("[ERROR] %s", msg);
  endtask

  // RGB565 from the three source bytes of a color
  function automatic logic [15:0] expect_rgb(input logic [31:0] base, input logic [7:0] idx);
    logic [31:0] addr;
    logic [7:0]  r;
    logic [7:0]  g;
    logic [7:0]  b;
    addr = base + 32'(idx) * 32'd3;
    r = mem_bytes[addr[10:0]];
    g = mem_bytes[addr[10:0] + 11'd1];
    b = mem_bytes[addr[10:0] + 11'd2];
    return {r[7:3], g[7:2], b[7:3]};  // top 5, 6, 5 bits
  endfunction

  // one load, optionally with a second start in the middle
  task automatic run_load(input string name, input logic [31:0] base, input bit second_start);
    int cycles;
    reads.delete();
    done_count = 0;
    @(posedge clk);
    start     <= 1'b1;
    base_addr <= base;
    @(posedge clk);
    start <= 1'b0;
    if (second_start) begin
      repeat (40) @(posedge clk);
      start     <= 1'b1;
      base_addr <= base + 32'd300;  // wrong base, must not be taken
      @(negedge clk);
      check_equal({name, " busy at second start"}, 32'd1, 32'(busy));
      @(posedge clk);
      start     <= 1'b0;
      base_addr <= base;
    end
    cycles = 0;
    while (!done && cycles < LOAD_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) note_failure({name, ": load never signalled done"});
    repeat (3) @(negedge clk);
    check_equal({name, " done pulses"}, 32'd1, 32'(done_count));
    check_equal({name, " read count"}, 32'(`PAL_BYTES), 32'(reads.size()));
    check_equal({name, " busy after done"}, 32'd0, 32'(busy));
    if (reads.size() == `PAL_BYTES) begin
      for (int k = 0; k < `PAL_BYTES; k++) begin
        check_equal({name, " address order"}, base + 32'(k), reads[k]);
      end
    end
  endtask

  // pixel stream, sequential indices or random ones with gaps
  task automatic run_lookups(input string name, input logic [31:0] base, input bit random_mode,
                             input int n);
    bit         hist_v [$];
    logic [7:0] hist_i [$];
    bit         v;
    logic [7:0] idx;
    for (int c = 0; c < n + 2; c++) begin
      @(posedge clk);
      if (c >= n) begin  // drain the pipe
        v   = 1'b0;
        idx = 8'd0;
      end else if (random_mode) begin
        v   = ($urandom % 4) != 0;
        idx = 8'($urandom);
      end else begin
        v   = 1'b1;
        idx = 8'(c);
      end
      pix_valid <= v;
      pix_index <= idx;
      @(negedge clk);
      hist_v.push_back(v);
      hist_i.push_back(idx);
      if (c >= 2) begin  // output now shows the pixel from two cycles back
        check_equal({name, " rgb_valid"}, 32'(hist_v[c - 2]), 32'(rgb_valid));
        if (hist_v[c - 2]) begin
          check_equal({name, " rgb"}, 32'(expect_rgb(base, hist_i[c - 2])), 32'(rgb));
        end else begin
          check_equal({name, " rgb idle"}, 32'd0, 32'(rgb));
        end
      end
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_equal("reset busy", 32'd0, 32'(busy));
    check_equal("reset done", 32'd0, 32'(done));
    check_equal("reset mem_read", 32'd0, 32'(mem_read));
    check_equal("reset rgb_valid", 32'd0, 32'(rgb_valid));
  endtask

  task automatic test_full_load();
    run_load("full_load", 32'd100, 1'b0);
    run_lookups("full_lookup", 32'd100, 1'b0, `PAL_ENTRIES);
  endtask

  task automatic test_start_while_busy();
    run_load("start_while_busy", 32'd100, 1'b1);
    run_lookups("start_while_busy lookup", 32'd100, 1'b0, `PAL_ENTRIES);
  endtask

  task automatic test_reload();
    run_load("reload", 32'd900, 1'b0);
    run_lookups("reload lookup", 32'd900, 1'b0, `PAL_ENTRIES);
  endtask

  task automatic test_lookup_pipeline();
    run_lookups("lookup_pipeline", 32'd900, 1'b1, 400);
  endtask

  initial begin
    void'($urandom(59));
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem_bytes[i] = 8'($urandom);
    end
    error_count = 0;
    check_count = 0;
    done_count  = 0;
    reset       = 1'b1;
    start       = 1'b0;
    base_addr   = '0;
    pix_valid   = 1'b0;
    pix_index   = 8'd0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_full_load();
    test_start_while_busy();
    test_reload();
    test_lookup_pipeline();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // upper bound on the whole run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: the run took too long and was stopped");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/palette_pkg.sv
common/palette_wr_if.sv
loader/palette_loader.sv
verilog/palette_store.sv
verilog/pixel_lookup.sv
verilog/palette_top.sv
verif/palette_tb.sv

/* run.sh */
#!/bin/sh
# build the palette testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module palette_tb -f files.f \
  --Mdir obj_dir -o palette_sim > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }
./obj_dir/palette_sim > sim.log 2>&1 || echo "simulator exited with an error status"
grep -q "RESULT: PASS" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
